/* verilog/cpu_consts.svh */
/*
 * Front end constants
 *  - data, address and register index widths
 *  - instruction FIFO depth and branch mask length
 *  - opcode and field positions used by the decode
 */

`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`default_nettype none

`define CPU_BITS                16
`define CPU_ADDRESS_BITS        16
`define CPU_REGISTER_BITS       4

// 8 entry instruction FIFO
`define CPU_FIFO_DEPTH_BITS     3

`define CPU_BRANCH_MASK_CYCLES  4

// Opcode fields
`define CPU_OPCODE_HI           15
`define CPU_OPCODE_LO           12
`define CPU_OPCODE_IMM          4'hF
`define CPU_IMM_BITS            12
`define CPU_IMM_LO_BITS         4
`define CPU_DEST_HI             11
`define CPU_DEST_LO             8
`define CPU_FLAG_BIT            7

`default_nettype wire

`endif

/* verilog/cpu_pkg.sv */
/*
 * Shared front end types
 *  - instruction, address and register index
 *  - FIFO entry pairing an address with its word
 *  - NOP encoding
 */

`include "cpu_consts.svh"

`default_nettype none

package cpu_pkg;

	typedef logic [`CPU_BITS - 1:0] instr_t;

	typedef logic [`CPU_ADDRESS_BITS - 1:0] addr_t;

	typedef logic [`CPU_REGISTER_BITS - 1:0] reg_idx_t;

	// Address in the upper half, word in the lower half
	typedef struct packed {
		addr_t  addr;
		instr_t instr;
	} fetch_entry_t;

	localparam instr_t NOP_INSTRUCTION = 16'h0000;

endpackage

`default_nettype wire

/* verilog/cpu_instruction_fifo.sv */
/*
 * Instruction FIFO
 *  - circular buffer, payload type set by parameter
 *  - single cycle flush
 *  - head visible on rd_data without a pop
 */

`default_nettype none

module cpu_instruction_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  DEPTH_BITS = 3
) (
	input  logic     CLK,
	input  logic     RSTb,

	input  logic     flush,

	input  payload_t wr_data,
	input  logic     wr,

	input  logic     rd,
	output payload_t rd_data,

	output logic     empty
);

	localparam int DEPTH = 1 << DEPTH_BITS;

	payload_t mem [DEPTH];

	// Extra bit tells a full buffer from an empty one
	logic [DEPTH_BITS:0] wr_ptr_r;
	logic [DEPTH_BITS:0] rd_ptr_r;

	assign empty   = wr_ptr_r == rd_ptr_r;
	assign rd_data = mem[rd_ptr_r[DEPTH_BITS - 1:0]];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
		end else if (flush) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
		end else begin
			if (wr)
				wr_ptr_r <= wr_ptr_r + 1'b1;
			if (rd && !empty)
				rd_ptr_r <= rd_ptr_r + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge CLK) begin
		if (wr && !flush)
			mem[wr_ptr_r[DEPTH_BITS - 1:0]] <= wr_data;
	end

endmodule

`default_nettype wire

/* verilog/cpu_fetch_unit.sv */
/*
 * Fetch unit
 *  - fetch PC and sequential memory requests
 *  - credit count, one credit per free FIFO slot
 *  - tags returned words with their request address
 *  - redirect on load_pc, drops stale returns
 */

`include "cpu_consts.svh"

`default_nettype none

module cpu_fetch_unit (
	input  logic                 CLK,
	input  logic                 RSTb,

	input  logic                 load_pc,
	input  cpu_pkg::addr_t       pc_in,

	input  logic                 fifo_pop,

	output logic                 mem_req,
	output cpu_pkg::addr_t       mem_addr,
	input  logic                 mem_valid,
	input  cpu_pkg::instr_t      mem_data,

	output logic                 fifo_wr,
	output cpu_pkg::fetch_entry_t fifo_entry,
	output logic                 fifo_flush
);

	import cpu_pkg::*;

	localparam int CREDIT_BITS = `CPU_FIFO_DEPTH_BITS + 1;
	localparam logic [CREDIT_BITS - 1:0] MAX_CREDITS = CREDIT_BITS'(1 << `CPU_FIFO_DEPTH_BITS);

	logic [CREDIT_BITS - 1:0] credits_r;
	logic                     enable_r;
	logic                     discard_r;
	addr_t                    pc_r;
	addr_t                    req_addr_r;

	// No request while redirecting or out of credit
	assign mem_req    = enable_r && (credits_r != '0) && !load_pc;
	assign mem_addr   = pc_r;
	assign fifo_flush = load_pc;

	// Returns in the redirect cycle or just after belong to the old path
	assign fifo_wr    = mem_valid && !load_pc && !discard_r;
	assign fifo_entry = {req_addr_r, mem_data};

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			enable_r  <= 1'b0;
			discard_r <= 1'b0;
			credits_r <= MAX_CREDITS;
			pc_r      <= '0;
		end else begin
			enable_r  <= 1'b1;
			discard_r <= load_pc;
			if (load_pc) begin
				pc_r      <= pc_in;
				credits_r <= MAX_CREDITS;
			end else begin
				if (mem_req)
					pc_r <= pc_r + 1'b1;
				case ({mem_req, fifo_pop})
					2'b10:   credits_r <= credits_r - 1'b1;
					2'b01:   credits_r <= credits_r + 1'b1;
					default: credits_r <= credits_r;
				endcase
			end
		end
	end

	// Memory answers one cycle later, so one address in flight
	always_ff @(posedge CLK) begin
		if (mem_req)
			req_addr_r <= pc_r;
	end

endmodule

`default_nettype wire

/* verilog/cpu_pipeline.sv */
/*
 * Instruction pipeline
 *  - five stages with their addresses
 *  - branch mask and flush after a PC load
 *  - stall bubbles, immediate prefix register
 *  - hazard index and flag bit chains
 */

`include "cpu_consts.svh"

`default_nettype none

module cpu_pipeline (
	input  logic                  CLK,
	input  logic                  RSTb,

	input  logic                  is_executing,
	input  logic                  stall,
	input  logic                  load_pc,

	input  cpu_pkg::fetch_entry_t fifo_entry,
	input  logic                  fifo_empty,
	output logic                  fifo_pop,

	output cpu_pkg::instr_t       pipeline_stage1,
	output cpu_pkg::instr_t       pipeline_stage2,
	output cpu_pkg::instr_t       pipeline_stage3,
	output cpu_pkg::instr_t       pipeline_stage4,
	output cpu_pkg::addr_t        pc_stage4,

	output cpu_pkg::instr_t       imm_reg,

	output cpu_pkg::reg_idx_t     hazard_reg1,
	output cpu_pkg::reg_idx_t     hazard_reg2,
	output cpu_pkg::reg_idx_t     hazard_reg3,
	output logic                  modifies_flags1,
	output logic                  modifies_flags2,
	output logic                  modifies_flags3
);

	import cpu_pkg::*;

	localparam int MASK_BITS = $clog2(`CPU_BRANCH_MASK_CYCLES + 1);

	function automatic logic is_imm(instr_t ins);
		return ins[`CPU_OPCODE_HI:`CPU_OPCODE_LO] == `CPU_OPCODE_IMM;
	endfunction

	// Destination register, zero for NOP and immediate prefix
	function automatic reg_idx_t dest_of(instr_t ins);
		if (ins == NOP_INSTRUCTION || is_imm(ins))
			return '0;
		return ins[`CPU_DEST_HI:`CPU_DEST_LO];
	endfunction

	function automatic logic flag_of(instr_t ins);
		if (ins == NOP_INSTRUCTION || is_imm(ins))
			return 1'b0;
		return ins[`CPU_FLAG_BIT];
	endfunction

	logic [MASK_BITS - 1:0]     mask_count_r;
	logic                       branch_mask;
	instr_t                     stage0;
	addr_t                      pc_stage0;
	addr_t                      pc_stage1_r;
	addr_t                      pc_stage2_r;
	addr_t                      pc_stage3_r;
	logic [`CPU_IMM_BITS - 1:0] imm_hi_r;

	assign branch_mask = mask_count_r != '0;

	// Stage 0 is the FIFO head, taken only on a clean shift
	assign fifo_pop  = is_executing && !stall && !load_pc && !branch_mask && !fifo_empty;
	assign stage0    = fifo_pop ? fifo_entry.instr : NOP_INSTRUCTION;
	assign pc_stage0 = fifo_pop ? fifo_entry.addr : '0;

	// Branch mask counts down after a PC load
	always_ff @(posedge CLK) begin
		if (!RSTb)
			mask_count_r <= '0;
		else if (load_pc)
			mask_count_r <= MASK_BITS'(`CPU_BRANCH_MASK_CYCLES);
		else if (branch_mask)
			mask_count_r <= mask_count_r - 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pipeline_stage1 <= NOP_INSTRUCTION;
			pipeline_stage2 <= NOP_INSTRUCTION;
			pipeline_stage3 <= NOP_INSTRUCTION;
			pipeline_stage4 <= NOP_INSTRUCTION;
			pc_stage1_r     <= '0;
			pc_stage2_r     <= '0;
			pc_stage3_r     <= '0;
			pc_stage4       <= '0;
			hazard_reg1     <= '0;
			hazard_reg2     <= '0;
			hazard_reg3     <= '0;
			modifies_flags1 <= 1'b0;
			modifies_flags2 <= 1'b0;
			modifies_flags3 <= 1'b0;
		end else begin
			if (is_executing) begin
				if (stall) begin
					// Stage 1 holds, bubble into stage 2
					pipeline_stage2 <= NOP_INSTRUCTION;
					pc_stage2_r     <= '0;
					hazard_reg2     <= '0;
					modifies_flags2 <= 1'b0;
				end else begin
					pipeline_stage1 <= stage0;
					pipeline_stage2 <= pipeline_stage1;
					pc_stage1_r     <= pc_stage0;
					pc_stage2_r     <= pc_stage1_r;
					hazard_reg1     <= dest_of(stage0);
					hazard_reg2     <= hazard_reg1;
					modifies_flags1 <= flag_of(stage0);
					modifies_flags2 <= modifies_flags1;
				end
				pipeline_stage3 <= pipeline_stage2;
				pipeline_stage4 <= pipeline_stage3;
				pc_stage3_r     <= pc_stage2_r;
				pc_stage4       <= pc_stage3_r;
				hazard_reg3     <= hazard_reg2;
				modifies_flags3 <= modifies_flags2;
			end
			// Flush the two youngest stages on a redirect
			if (load_pc) begin
				pipeline_stage1 <= NOP_INSTRUCTION;
				pipeline_stage2 <= NOP_INSTRUCTION;
				pc_stage1_r     <= '0;
				pc_stage2_r     <= '0;
				hazard_reg1     <= '0;
				hazard_reg2     <= '0;
				modifies_flags1 <= 1'b0;
				modifies_flags2 <= 1'b0;
			end
		end
	end

	// Immediate prefix register
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			imm_hi_r <= '0;
			imm_reg  <= '0;
		end else begin
			if (is_imm(pipeline_stage1) && !load_pc)
				imm_hi_r <= pipeline_stage1[`CPU_IMM_BITS - 1:0];
			else if (is_executing && !stall && !load_pc && pipeline_stage1 != NOP_INSTRUCTION)
				imm_hi_r <= '0;
			if (is_executing)
				imm_reg <= {imm_hi_r, pipeline_stage1[`CPU_IMM_LO_BITS - 1:0]};
		end
	end

endmodule

`default_nettype wire

/* verilog/cpu_frontend.sv */
/*
 * CPU front end top level
 *  - fetch unit, instruction FIFO and pipeline
 */

`include "cpu_consts.svh"

`default_nettype none

module cpu_frontend (
	input  logic              CLK,
	input  logic              RSTb,

	output logic              mem_req,
	output cpu_pkg::addr_t    mem_addr,
	input  logic              mem_valid,
	input  cpu_pkg::instr_t   mem_data,

	input  logic              is_executing,
	input  logic              stall,
	input  logic              load_pc,
	input  cpu_pkg::addr_t    pc_in,

	output cpu_pkg::instr_t   pipeline_stage1,
	output cpu_pkg::instr_t   pipeline_stage2,
	output cpu_pkg::instr_t   pipeline_stage3,
	output cpu_pkg::instr_t   pipeline_stage4,
	output cpu_pkg::addr_t    pc_stage4,
	output cpu_pkg::instr_t   imm_reg,

	output cpu_pkg::reg_idx_t hazard_reg1,
	output cpu_pkg::reg_idx_t hazard_reg2,
	output cpu_pkg::reg_idx_t hazard_reg3,
	output logic              modifies_flags1,
	output logic              modifies_flags2,
	output logic              modifies_flags3
);

	import cpu_pkg::*;

	logic         fifo_wr;
	logic         fifo_pop;
	logic         fifo_flush;
	logic         fifo_empty;
	fetch_entry_t fifo_wr_entry;
	fetch_entry_t fifo_head;

	cpu_fetch_unit u_fetch (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.load_pc    (load_pc),
		.pc_in      (pc_in),
		.fifo_pop   (fifo_pop),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_valid  (mem_valid),
		.mem_data   (mem_data),
		.fifo_wr    (fifo_wr),
		.fifo_entry (fifo_wr_entry),
		.fifo_flush (fifo_flush)
	);

	cpu_instruction_fifo #(
		.payload_t  (fetch_entry_t),
		.DEPTH_BITS (`CPU_FIFO_DEPTH_BITS)
	) u_fifo (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.flush   (fifo_flush),
		.wr_data (fifo_wr_entry),
		.wr      (fifo_wr),
		.rd      (fifo_pop),
		.rd_data (fifo_head),
		.empty   (fifo_empty)
	);

	cpu_pipeline u_pipeline (
		.CLK             (CLK),
		.RSTb            (RSTb),
		.is_executing    (is_executing),
		.stall           (stall),
		.load_pc         (load_pc),
		.fifo_entry      (fifo_head),
		.fifo_empty      (fifo_empty),
		.fifo_pop        (fifo_pop),
		.pipeline_stage1 (pipeline_stage1),
		.pipeline_stage2 (pipeline_stage2),
		.pipeline_stage3 (pipeline_stage3),
		.pipeline_stage4 (pipeline_stage4),
		.pc_stage4       (pc_stage4),
		.imm_reg         (imm_reg),
		.hazard_reg1     (hazard_reg1),
		.hazard_reg2     (hazard_reg2),
		.hazard_reg3     (hazard_reg3),
		.modifies_flags1 (modifies_flags1),
		.modifies_flags2 (modifies_flags2),
		.modifies_flags3 (modifies_flags3)
	);

endmodule

`default_nettype wire

/* verification/cpu_frontend_tb.sv */
/*
 * Front end testbench
 *  - clock, reset and a one cycle latency memory model
 *  - random execute side stimulus with occasional redirects
 *  - reference models for fetch order, decode and immediate register
 *  - concurrent assertions with error counters and a closing report
 */

`include "cpu_consts.svh"

`default_nettype none

module cpu_frontend_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import cpu_pkg::*;

	localparam int REQ_TIMEOUT    = 32;
	localparam int RUN_TIMEOUT    = 20000;
	localparam int RETIRE_TARGET  = 600;

	logic    CLK          = 1'b0;
	logic    RSTb         = 1'b0;
	logic    is_executing = 1'b0;
	logic    stall        = 1'b0;
	logic    load_pc      = 1'b0;
	addr_t   pc_in        = '0;
	logic    mem_valid    = 1'b0;
	instr_t  mem_data     = '0;

	logic    mem_req;
	addr_t   mem_addr;
	instr_t  pipeline_stage1;
	instr_t  pipeline_stage2;
	instr_t  pipeline_stage3;
	instr_t  pipeline_stage4;
	addr_t   pc_stage4;
	instr_t  imm_reg;
	reg_idx_t hazard_reg1;
	reg_idx_t hazard_reg2;
	reg_idx_t hazard_reg3;
	logic    modifies_flags1;
	logic    modifies_flags2;
	logic    modifies_flags3;

	integer      seed = 32'h60e9ef28;
	logic [31:0] rnd;
	logic        run_en = 1'b0;
	int          since_load = 0;
	int          retired = 0;

	// Reference model state
	logic        reset_held = 1'b0;
	addr_t       expect_addr = '0;
	addr_t       target_addr = '0;
	logic        redirect_pending = 1'b0;
	int          old_left = 0;
	logic        stage4_new = 1'b0;
	logic        flush_seen = 1'b0;
	logic        stall_seen = 1'b0;
	instr_t      stage1_prev = '0;
	logic [11:0] imm_hi_model = '0;
	instr_t      imm_expect = '0;
	logic        order_ok;

	int err_reset = 0;
	int err_word = 0;
	int err_order = 0;
	int err_bubble = 0;
	int err_decode = 0;
	int err_imm = 0;
	int timeouts = 0;

	cpu_frontend DUT (.*);

	always #10 CLK = ~CLK;

	// Program image, NOP every eighth word, prefixes at offsets 3 and 6
	function automatic instr_t program_word(addr_t a);
		instr_t w;
		case (a[2:0])
			3'd0: w = NOP_INSTRUCTION;
			3'd3,
			3'd6: w = {`CPU_OPCODE_IMM, a[11:0] ^ 12'hA5C};
			default: begin
				w[15:12] = {1'b0, a[5:3]} | 4'h1;
				w[11:8]  = a[11:8] ^ a[15:12];
				w[7]     = a[3] ^ a[10];
				w[6:0]   = a[6:0] ^ a[13:7];
			end
		endcase
		return w;
	endfunction

	// Next address whose word is visible at stage 4
	function automatic addr_t next_program_addr(addr_t a);
		addr_t n;
		int    i;
		n = a + 16'd1;
		for (i = 0; i < 8 && program_word(n) == NOP_INSTRUCTION; i++)
			n = n + 16'd1;
		return n;
	endfunction

	function automatic reg_idx_t decode_dest(instr_t ins);
		if (ins == NOP_INSTRUCTION || ins[15:12] == `CPU_OPCODE_IMM)
			return '0;
		return ins[`CPU_DEST_HI:`CPU_DEST_LO];
	endfunction

	function automatic logic decode_flag(instr_t ins);
		if (ins == NOP_INSTRUCTION || ins[15:12] == `CPU_OPCODE_IMM)
			return 1'b0;
		return ins[`CPU_FLAG_BIT];
	endfunction

	// Redirect target away from the words still in flight
	function automatic addr_t pick_target(addr_t raw, addr_t current);
		addr_t t;
		t = raw;
		if (t[2:0] == 3'd0)
			t[0] = 1'b1;
		if (addr_t'(t - current) < 16'd32)
			t = t + 16'd64;
		return t;
	endfunction

	// Memory answers one cycle after each request
	always @(posedge CLK) begin
		mem_valid <= mem_req;
		mem_data  <= program_word(mem_addr);
	end

	// Execute side stimulus
	always @(posedge CLK) begin
		rnd = $random(seed);
		if (!run_en) begin
			is_executing <= 1'b0;
			stall        <= 1'b0;
			load_pc      <= 1'b0;
		end else begin
			is_executing <= rnd[2:0] != 3'd0;
			stall        <= rnd[7:4] < 4'd3;
			if (rnd[15:11] == 5'd0 && since_load > 16 && !redirect_pending) begin
				load_pc    <= 1'b1;
				pc_in      <= pick_target(rnd[31:16], expect_addr);
				since_load <= 0;
			end else begin
				load_pc <= 1'b0;
				if (since_load < 255)
					since_load <= since_load + 1;
			end
		end
	end

	// A new stage 4 word is the expected one, or the target once the old words are out
	assign order_ok = !stage4_new || pipeline_stage4 == NOP_INSTRUCTION ||
		(redirect_pending && pc_stage4 == target_addr) ||
		(pc_stage4 == expect_addr && (!redirect_pending || old_left != 0));

	always @(posedge CLK) begin
		reset_held <= !RSTb;
		if (!RSTb) begin
			expect_addr      <= next_program_addr(16'hFFFF);
			target_addr      <= '0;
			redirect_pending <= 1'b0;
			old_left         <= 0;
			stage4_new       <= 1'b0;
			flush_seen       <= 1'b0;
			stall_seen       <= 1'b0;
			stage1_prev      <= '0;
			imm_hi_model     <= '0;
			imm_expect       <= '0;
			retired          <= 0;
		end else begin
			flush_seen  <= load_pc;
			stall_seen  <= is_executing && stall && !load_pc;
			stage1_prev <= pipeline_stage1;
			// Stage 4 holds its word while not executing
			stage4_new  <= is_executing;
			if (stage4_new && pipeline_stage4 != NOP_INSTRUCTION) begin
				retired     <= retired + 1;
				expect_addr <= next_program_addr(pc_stage4);
				if (redirect_pending && pc_stage4 == target_addr)
					redirect_pending <= 1'b0;
				else if (redirect_pending && old_left != 0)
					old_left <= old_left - 1;
			end
			if (load_pc) begin
				redirect_pending <= 1'b1;
				target_addr      <= pc_in;
				// Old words left in stages 2 and 3
				old_left         <= 2;
			end
			// Immediate prefix rules
			if (pipeline_stage1[15:12] == `CPU_OPCODE_IMM && !load_pc)
				imm_hi_model <= pipeline_stage1[11:0];
			else if (is_executing && !stall && !load_pc && pipeline_stage1 != NOP_INSTRUCTION)
				imm_hi_model <= '0;
			if (is_executing)
				imm_expect <= {imm_hi_model, pipeline_stage1[3:0]};
		end
	end

	assert property (@(posedge CLK) !(reset_held && !RSTb) ||
		(!mem_req && pipeline_stage1 == '0 && pipeline_stage2 == '0 &&
		pipeline_stage3 == '0 && pipeline_stage4 == '0 && imm_reg == '0 &&
		hazard_reg1 == '0 && !modifies_flags1))
	else begin
		err_reset++;
		$display("MISMATCH in reset mem_req=%h stage1=%h stage2=%h stage3=%h stage4=%h imm_reg=%h",
			$sampled(mem_req), $sampled(pipeline_stage1), $sampled(pipeline_stage2),
			$sampled(pipeline_stage3), $sampled(pipeline_stage4), $sampled(imm_reg));
	end

	assert property (@(posedge CLK) disable iff (!RSTb)
		pipeline_stage4 == NOP_INSTRUCTION || pipeline_stage4 == program_word(pc_stage4))
	else begin
		err_word++;
		$display("MISMATCH pipeline_stage4 at %h got %h expected %h", $sampled(pc_stage4),
			$sampled(pipeline_stage4), program_word($sampled(pc_stage4)));
	end

	assert property (@(posedge CLK) disable iff (!RSTb) order_ok)
	else begin
		err_order++;
		$display("MISMATCH pc_stage4 got %h expected %h or target %h", $sampled(pc_stage4),
			$sampled(expect_addr), $sampled(target_addr));
	end

	assert property (@(posedge CLK) disable iff (!RSTb)
		!flush_seen || (pipeline_stage1 == '0 && pipeline_stage2 == '0))
	else begin
		err_bubble++;
		$display("MISMATCH after load_pc pipeline_stage1=%h pipeline_stage2=%h expected 0000",
			$sampled(pipeline_stage1), $sampled(pipeline_stage2));
	end

	assert property (@(posedge CLK) disable iff (!RSTb)
		!stall_seen || (pipeline_stage2 == '0 && pipeline_stage1 == stage1_prev))
	else begin
		err_bubble++;
		$display("MISMATCH after stall pipeline_stage1=%h expected %h pipeline_stage2=%h",
			$sampled(pipeline_stage1), $sampled(stage1_prev), $sampled(pipeline_stage2));
	end

	assert property (@(posedge CLK) disable iff (!RSTb)
		hazard_reg1 == decode_dest(pipeline_stage1) &&
		hazard_reg2 == decode_dest(pipeline_stage2) &&
		hazard_reg3 == decode_dest(pipeline_stage3) &&
		modifies_flags1 == decode_flag(pipeline_stage1) &&
		modifies_flags2 == decode_flag(pipeline_stage2) &&
		modifies_flags3 == decode_flag(pipeline_stage3))
	else begin
		err_decode++;
		$display("MISMATCH hazard_reg1..3=%h %h %h modifies_flags1..3=%h %h %h",
			$sampled(hazard_reg1), $sampled(hazard_reg2), $sampled(hazard_reg3),
			$sampled(modifies_flags1), $sampled(modifies_flags2), $sampled(modifies_flags3));
	end

	assert property (@(posedge CLK) disable iff (!RSTb) imm_reg == imm_expect)
	else begin
		err_imm++;
		$display("MISMATCH imm_reg got %h expected %h", $sampled(imm_reg), $sampled(imm_expect));
	end

	task automatic wait_for_request(output logic ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < REQ_TIMEOUT && !ok; n++) begin
			@(posedge CLK);
			if (mem_req)
				ok = 1'b1;
		end
		if (!ok) begin
			timeouts++;
			$display("Timeout: no memory request after reset");
		end
	endtask

	task automatic wait_for_retired(input int count, output logic ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < RUN_TIMEOUT && !ok; n++) begin
			@(posedge CLK);
			if (retired >= count)
				ok = 1'b1;
		end
		if (!ok) begin
			timeouts++;
			$display("Timeout: only %0d instructions reached stage 4", retired);
		end
	endtask

	task automatic report_and_finish();
		int total;
		total = err_reset + err_word + err_order + err_bubble + err_decode + err_imm + timeouts;
		$write("Retired %0d, errors reset %0d word %0d order %0d",
			retired, err_reset, err_word, err_order);
		$display(" bubble %0d decode %0d imm %0d timeout %0d",
			err_bubble, err_decode, err_imm, timeouts);
		if (total == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	endtask

	initial begin
		logic ok;
		repeat (10) @(posedge CLK);
		RSTb <= 1'b1;
		wait_for_request(ok);
		if (ok) begin
			run_en <= 1'b1;
			wait_for_retired(RETIRE_TARGET, ok);
		end
		run_en <= 1'b0;
		@(posedge CLK);
		report_and_finish();
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/cpu_instruction_fifo.sv
verilog/cpu_fetch_unit.sv
verilog/cpu_pipeline.sv
verilog/cpu_frontend.sv
verification/cpu_frontend_tb.sv

/* Makefile */
TOP = cpu_frontend_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "SIMULATION FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
